//--- src.f
design/env_cfg_pkg.sv
design/env_state_pkg.sv
design/env_param_regs.sv
design/env_slot_sequencer.sv
design/env_state_ram.sv
design/env_step_engine.sv
design/env_gen_top.sv
sim/tb_clock_gen.sv
sim/env_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the envelope generator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module env_gen_tb \
    -o env_gen_sim

./obj_dir/env_gen_sim

//--- sim/env_gen_tb.sv
// envelope generator testbench with LFSR parameters, key runs and assertion checks
`timescale 1ns/1ps
`default_nettype none

module env_gen_tb;

    localparam int VOICES = 4;
    localparam int V_ENVS = 4;
    localparam int MAIN_ENV = 1;
    localparam int SLOTS = VOICES * V_ENVS;
    localparam int RAMP_MAX = 128 * 9 + 2;  // visits of a rate-3 ramp
    // two key runs of four worst ramps each plus setup
    localparam int LIMIT = 2 * (4 * (RAMP_MAX + 4) + 8) * SLOTS + 4000;

    logic sCLK_XVXENVS, reset_reg_N;
    logic write, read;
    logic [6:0] adr;
    logic [7:0] wr_data, rd_data, level_out;
    logic [VOICES-1:0] keys_on, voice_free;
    logic [1:0] level_voice, level_env;
    logic level_valid;

    logic [7:0] shadow [128];
    logic [7:0] rd_exp;
    logic [7:0] exp_d;
    logic read_d;
    logic [15:0] lfsr;
    logic [3:0] prev_slot;
    logic prev_valid;
    logic sus_on, rel_on;
    logic [1:0] cur_v;
    int cyc;
    int key_cnt;

    tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(2)) clk_i (.sCLK_XVXENVS, .reset_reg_N);

    env_gen_top #(.VOICES(VOICES), .V_ENVS(V_ENVS), .MAIN_ENV(MAIN_ENV)) dut_i (
        .sCLK_XVXENVS, .reset_reg_N, .write, .read, .adr, .wr_data, .rd_data,
        .keys_on, .level_out, .level_voice, .level_env, .level_valid, .voice_free
    );

    task automatic fail_check(input string name, input longint exp, input longint act);
        $display("TEST FAIL");
        $display("error %s expected %0d actual %0d", name, exp, act);
        $fatal(1, "check %s failed", name);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] seg_lvl(input logic [1:0] env, input int seg);
        return {1'b0, shadow[int'(env) * 8 + 4 + seg][6:0]};
    endfunction

    function automatic int ramp_visits(input logic [7:0] rate);
        return (rate == 0) ? 1 : 128 * int'(rate) * int'(rate) + 2;
    endfunction

    always_ff @(posedge sCLK_XVXENVS or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            cyc        <= 0;
            key_cnt    <= 0;
            prev_valid <= 1'b0;
            prev_slot  <= '0;
            read_d     <= 1'b0;
            exp_d      <= '0;
        end else begin
            cyc        <= cyc + 1;
            key_cnt    <= keys_on[cur_v] ? key_cnt + 1 : 0;
            prev_valid <= level_valid;
            prev_slot  <= {level_voice, level_env};
            read_d     <= read;
            exp_d      <= rd_exp;
        end
    end

    always @(posedge sCLK_XVXENVS) begin
        if (cyc >= LIMIT) begin
            $display("TEST FAIL");
            $fatal(1, "timeout: run did not finish within %0d cycles", LIMIT);
        end
    end

    // sweep plus two pipeline cycles before the first valid level
    a_init_quiet: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (cyc < SLOTS + 2) |-> (!level_valid && voice_free == '1 && rd_data == '0)
    ) else fail_check("init_quiet", {1'b0, {VOICES{1'b1}}, 8'h00},
                      {$sampled(level_valid), $sampled(voice_free), $sampled(rd_data)});

    a_stream: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (cyc >= SLOTS + 2) |-> level_valid
    ) else fail_check("stream_valid", 1, $sampled(level_valid));

    a_order: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (level_valid && prev_valid) |-> {level_voice, level_env} == prev_slot + 4'd1
    ) else fail_check("slot_order", $sampled(prev_slot) + 4'd1,
                      $sampled({level_voice, level_env}));

    a_readback: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        read_d |-> rd_data == exp_d
    ) else fail_check("readback", $sampled(exp_d), $sampled(rd_data));

    a_range: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        level_valid |-> level_out <= 8'd127
    ) else fail_check("level_range", 127, $sampled(level_out));

    a_sustain: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (sus_on && level_valid && level_voice == cur_v) |-> level_out == seg_lvl(level_env, 2)
    ) else fail_check("sustain_level", seg_lvl($sampled(level_env), 2), $sampled(level_out));

    a_free_held: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (key_cnt > 2 * SLOTS) |-> !voice_free[cur_v]
    ) else fail_check("voice_free_held", 0, $sampled(voice_free[cur_v]));

    a_release: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        (rel_on && level_valid && level_voice == cur_v) |-> level_out == seg_lvl(level_env, 3)
    ) else fail_check("release_level", seg_lvl($sampled(level_env), 3), $sampled(level_out));

    a_free_back: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_reg_N)
        rel_on |-> voice_free[cur_v]
    ) else fail_check("voice_free_done", 1, $sampled(voice_free[cur_v]));

    task automatic write_reg(input int a, input logic [7:0] d);
        @(negedge sCLK_XVXENVS);
        write   = 1'b1;
        adr     = 7'(a);
        wr_data = d;
        if (a < 32)
            shadow[a] = d;  // env_idx 4 and up is unmapped
    endtask

    // keys one voice through sustain and release for the worst-case ramp time
    task automatic run_voice(input logic [1:0] v);
        int sus_visits;
        int rel_visits;
        int seg_sum;
        sus_visits = 0;
        rel_visits = 0;
        for (int e = 0; e < V_ENVS; e++) begin
            seg_sum = 3;
            for (int s = 0; s < 3; s++)
                seg_sum += ramp_visits(shadow[e * 8 + s]);
            if (seg_sum > sus_visits)
                sus_visits = seg_sum;
            if (ramp_visits(shadow[e * 8 + 3]) + 1 > rel_visits)
                rel_visits = ramp_visits(shadow[e * 8 + 3]) + 1;
        end
        @(negedge sCLK_XVXENVS);
        cur_v = v;
        keys_on[v] = 1'b1;
        repeat ((sus_visits + 3) * SLOTS) @(negedge sCLK_XVXENVS);
        sus_on = 1'b1;
        repeat (4 * SLOTS) @(negedge sCLK_XVXENVS);
        sus_on = 1'b0;
        keys_on[v] = 1'b0;
        repeat ((rel_visits + 3) * SLOTS) @(negedge sCLK_XVXENVS);
        rel_on = 1'b1;
        repeat (4 * SLOTS) @(negedge sCLK_XVXENVS);
        rel_on = 1'b0;
    endtask

    initial begin
        logic [7:0] v;
        write   = 1'b0;
        read    = 1'b0;
        adr     = '0;
        wr_data = '0;
        keys_on = '0;
        rd_exp  = '0;
        sus_on  = 1'b0;
        rel_on  = 1'b0;
        cur_v   = '0;
        lfsr    = 16'd38016;
        for (int a = 0; a < 128; a++)
            shadow[a] = '0;
        @(posedge reset_reg_N);
        for (int a = 0; a < 32; a++) begin
            take_bits(a[2] ? 7 : 2, v);  // rates 0..3 and levels 0..127
            write_reg(a, v);
        end
        for (int a = 32; a < 128; a += 23) begin
            take_bits(8, v);
            write_reg(a, v);
        end
        @(negedge sCLK_XVXENVS);
        write = 1'b0;
        for (int a = 0; a < 128; a++) begin
            read   = 1'b1;
            adr    = 7'(a);
            rd_exp = shadow[a];
            @(negedge sCLK_XVXENVS);
        end
        read = 1'b0;
        run_voice(2'd0);
        for (int e = 0; e < V_ENVS; e++)
            for (int s = 0; s < 4; s++)
                write_reg(e * 8 + s, 8'd0);  // all rates zero
        @(negedge sCLK_XVXENVS);
        write = 1'b0;
        run_voice(2'd1);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic sCLK_XVXENVS,
    output logic reset_reg_N
);

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #(PERIOD / 2) sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    initial begin
        reset_reg_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge sCLK_XVXENVS);
        @(negedge sCLK_XVXENVS);
        reset_reg_N = 1'b1;  // released away from the active edge
    end

endmodule

`default_nettype wire

//--- design/env_gen_top.sv
// envelope generator top: parameter registers, slot sequencer, state RAM, step engine
`timescale 1ns/1ps
`default_nettype none

module env_gen_top #(
    parameter int VOICES   = 8,
    parameter int V_ENVS   = 8,
    parameter int MAIN_ENV = 1,
    localparam int V_W = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int E_W = (V_ENVS > 1) ? $clog2(V_ENVS) : 1
) (
    input  logic                           sCLK_XVXENVS,
    input  logic                           reset_reg_N,
    input  logic                           write,
    input  logic                           read,
    input  logic [env_cfg_pkg::ADDR_W-1:0] adr,
    input  logic [env_cfg_pkg::DATA_W-1:0] wr_data,
    output logic [env_cfg_pkg::DATA_W-1:0] rd_data,
    input  logic [VOICES-1:0]              keys_on,
    output logic [7:0]                     level_out,
    output logic [V_W-1:0]                 level_voice,
    output logic [E_W-1:0]                 level_env,
    output logic                           level_valid,
    output logic [VOICES-1:0]              voice_free
);

    logic [V_W-1:0] slot_voice;
    logic [E_W-1:0] slot_env;
    logic slot_go;
    logic init_wr;
    logic [env_state_pkg::STATE_W-1:0] rd_state;
    logic [env_state_pkg::STATE_W-1:0] wr_state;
    logic wr_en;
    logic [V_W-1:0] wr_voice;
    logic [E_W-1:0] wr_env;
    logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_rate;
    logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_level;

    env_param_regs #(.V_ENVS(V_ENVS)) regs_i (
        .sCLK_XVXENVS, .reset_reg_N, .write, .read, .adr, .wr_data, .rd_data,
        .slot_env, .seg_rate, .seg_level
    );

    env_slot_sequencer #(.VOICES(VOICES), .V_ENVS(V_ENVS)) seq_i (
        .sCLK_XVXENVS, .reset_reg_N, .slot_voice, .slot_env, .slot_go, .init_wr
    );

    env_state_ram #(.VOICES(VOICES), .V_ENVS(V_ENVS)) ram_i (
        .sCLK_XVXENVS, .slot_voice, .slot_env, .rd_state,
        .wr_en, .wr_voice, .wr_env, .wr_state
    );

    env_step_engine #(.VOICES(VOICES), .V_ENVS(V_ENVS), .MAIN_ENV(MAIN_ENV)) eng_i (
        .sCLK_XVXENVS, .reset_reg_N, .slot_go, .init_wr, .slot_voice, .slot_env,
        .rd_state, .seg_rate, .seg_level, .keys_on,
        .wr_en, .wr_voice, .wr_env, .wr_state,
        .level_out, .level_voice, .level_env, .level_valid, .voice_free
    );

endmodule

`default_nettype wire

//--- design/env_step_engine.sv
// envelope step engine: per-slot phase FSM, ramp step divider, level output
`timescale 1ns/1ps
`default_nettype none

module env_step_engine #(
    parameter int VOICES   = 8,
    parameter int V_ENVS   = 8,
    parameter int MAIN_ENV = 1,
    localparam int V_W = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int E_W = (V_ENVS > 1) ? $clog2(V_ENVS) : 1,
    localparam int SW  = env_state_pkg::STATE_W
) (
    input  logic              sCLK_XVXENVS,
    input  logic              reset_reg_N,
    input  logic              slot_go,
    input  logic              init_wr,
    input  logic [V_W-1:0]    slot_voice,
    input  logic [E_W-1:0]    slot_env,
    input  logic [SW-1:0]     rd_state,
    input  logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_rate,
    input  logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_level,
    input  logic [VOICES-1:0] keys_on,
    output logic              wr_en,
    output logic [V_W-1:0]    wr_voice,
    output logic [E_W-1:0]    wr_env,
    output logic [SW-1:0]     wr_state,
    output logic [7:0]        level_out,
    output logic [V_W-1:0]    level_voice,
    output logic [E_W-1:0]    level_env,
    output logic              level_valid,
    output logic [VOICES-1:0] voice_free
);

    localparam int LW = env_state_pkg::LEVEL_W;
    localparam int FW = env_state_pkg::FRAC_W;

    logic go_d;
    logic init_d;
    logic [V_W-1:0] voice_d;
    logic [E_W-1:0] env_d;
    env_state_pkg::env_phase_e ph, n_ph, ramp_next;
    logic signed [LW-1:0] lvl, stp, sum, tgt, sus_lvl;
    logic signed [LW-1:0] n_lvl, n_stp;
    logic signed [LW-1:0] ent_diff, ent_den, ent_step;
    logic [7:0] start, n_start, ent_start;
    logic [1:0] ramp_seg, ent_seg;
    logic key, reached;

    assign ph    = env_state_pkg::env_phase_e'(rd_state[SW-1 -: 4]);
    assign lvl   = rd_state[SW-5 -: LW];
    assign stp   = rd_state[8 +: LW];
    assign start = rd_state[7:0];
    assign key   = keys_on[voice_d];

    always_comb begin
        ramp_seg  = env_cfg_pkg::SEG_RELEASE;
        ramp_next = env_state_pkg::DONE;
        case (ph)
            env_state_pkg::ATTACK: begin
                ramp_seg  = env_cfg_pkg::SEG_ATTACK;
                ramp_next = env_state_pkg::HOLD1;
            end
            env_state_pkg::DECAY1: begin
                ramp_seg  = env_cfg_pkg::SEG_DECAY1;
                ramp_next = env_state_pkg::HOLD2;
            end
            env_state_pkg::DECAY2: begin
                ramp_seg  = env_cfg_pkg::SEG_DECAY2;
                ramp_next = env_state_pkg::SUSTAIN;
            end
            default: ;
        endcase
    end

    // segment that would be entered from this phase
    always_comb begin
        case (ph)
            env_state_pkg::IDLE, env_state_pkg::DONE: ent_seg = env_cfg_pkg::SEG_ATTACK;
            env_state_pkg::HOLD1: ent_seg = key ? env_cfg_pkg::SEG_DECAY1 : env_cfg_pkg::SEG_RELEASE;
            env_state_pkg::HOLD2: ent_seg = key ? env_cfg_pkg::SEG_DECAY2 : env_cfg_pkg::SEG_RELEASE;
            default: ent_seg = env_cfg_pkg::SEG_RELEASE;
        endcase
    end

    assign ent_start = lvl[LW-1:FW];
    assign ent_diff  = LW'(seg_level[ent_seg][6:0]) - LW'(ent_start);
    assign ent_den   = (seg_rate[ent_seg] == '0) ? LW'(1)
                     : LW'(seg_rate[ent_seg] * seg_rate[ent_seg]);  // rate squared
    assign ent_step  = (ent_diff <<< env_state_pkg::NUM_SHIFT) / ent_den;

    assign tgt     = LW'(seg_level[ramp_seg][6:0]) << FW;
    assign sus_lvl = LW'(seg_level[env_cfg_pkg::SEG_DECAY2][6:0]) << FW;
    assign sum     = lvl + stp;
    assign reached = (seg_rate[ramp_seg] == '0) || (stp[LW-1] ? (sum <= tgt) : (sum >= tgt));

    always_comb begin
        n_ph    = ph;
        n_lvl   = lvl;
        n_stp   = stp;
        n_start = start;
        case (ph)
            env_state_pkg::IDLE, env_state_pkg::DONE: begin
                if (key) begin
                    n_ph    = env_state_pkg::ATTACK;
                    n_stp   = ent_step;
                    n_start = ent_start;
                end else if (ph == env_state_pkg::IDLE) begin
                    n_lvl = '0;
                end
            end
            env_state_pkg::ATTACK, env_state_pkg::DECAY1, env_state_pkg::DECAY2,
            env_state_pkg::RELEASE: begin
                if (!key && ph != env_state_pkg::RELEASE) begin
                    n_ph    = env_state_pkg::RELEASE;
                    n_stp   = ent_step;
                    n_start = ent_start;
                end else if (reached) begin
                    n_lvl = tgt;  // clamp onto the target
                    n_ph  = ramp_next;
                end else begin
                    n_lvl = sum;
                end
            end
            env_state_pkg::HOLD1, env_state_pkg::HOLD2: begin
                if (!key)
                    n_ph = env_state_pkg::RELEASE;
                else
                    n_ph = (ph == env_state_pkg::HOLD1) ? env_state_pkg::DECAY1
                                                         : env_state_pkg::DECAY2;
                n_stp   = ent_step;
                n_start = ent_start;
            end
            env_state_pkg::SUSTAIN: begin
                if (key) begin
                    n_lvl = sus_lvl;
                end else begin
                    n_ph    = env_state_pkg::RELEASE;
                    n_stp   = ent_step;
                    n_start = ent_start;
                end
            end
            default: begin
                n_ph  = env_state_pkg::IDLE;
                n_lvl = '0;
            end
        endcase
    end

    always_ff @(posedge sCLK_XVXENVS or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            go_d        <= 1'b0;
            init_d      <= 1'b0;
            voice_d     <= '0;
            env_d       <= '0;
            wr_en       <= 1'b0;
            level_valid <= 1'b0;
            voice_free  <= '1;
        end else begin
            go_d        <= slot_go;
            init_d      <= init_wr;
            voice_d     <= slot_voice;
            env_d       <= slot_env;
            wr_en       <= go_d | init_d;
            level_valid <= go_d;
            if (go_d && env_d == E_W'(MAIN_ENV))
                voice_free[voice_d] <= (n_ph == env_state_pkg::IDLE) ||
                                       (n_ph == env_state_pkg::DONE);
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        wr_voice    <= voice_d;
        wr_env      <= env_d;
        level_voice <= voice_d;
        level_env   <= env_d;
        level_out   <= n_lvl[LW-1:FW];
        if (init_d)
            wr_state <= {env_state_pkg::IDLE, {(SW-4){1'b0}}};  // cleared slot
        else
            wr_state <= {n_ph, n_lvl, n_stp, n_start};
    end

    a_level_range: assert property (
        @(posedge sCLK_XVXENVS) disable iff (!reset_reg_N) level_valid |-> level_out <= 8'd127
    ) else $error("env_step_engine: level_out above 127");

endmodule

`default_nettype wire

//--- design/env_state_ram.sv
// per-slot envelope state memory with registered read
`timescale 1ns/1ps
`default_nettype none

module env_state_ram #(
    parameter int VOICES = 8,
    parameter int V_ENVS = 8,
    localparam int V_W = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int E_W = (V_ENVS > 1) ? $clog2(V_ENVS) : 1,
    localparam int SW  = env_state_pkg::STATE_W
) (
    input  logic           sCLK_XVXENVS,
    input  logic [V_W-1:0] slot_voice,
    input  logic [E_W-1:0] slot_env,
    output logic [SW-1:0]  rd_state,
    input  logic           wr_en,
    input  logic [V_W-1:0] wr_voice,
    input  logic [E_W-1:0] wr_env,
    input  logic [SW-1:0]  wr_state
);

    logic [SW-1:0] mem [VOICES * V_ENVS];
    int rd_idx;
    int wr_idx;

    assign rd_idx = int'(slot_voice) * V_ENVS + int'(slot_env);
    assign wr_idx = int'(wr_voice) * V_ENVS + int'(wr_env);

    always_ff @(posedge sCLK_XVXENVS) begin
        if (wr_en)
            mem[wr_idx] <= wr_state;
        rd_state <= mem[rd_idx];
    end

    // the write-back trails the read address by two slots
    a_no_overlap: assert property (
        @(posedge sCLK_XVXENVS) wr_en |-> (VOICES * V_ENVS >= 4) && (wr_idx != rd_idx)
    ) else $error("env_state_ram: slot read before its write-back, need 4+ slots");

endmodule

`default_nettype wire

//--- design/env_slot_sequencer.sv
// slot sequencer: one init sweep over all slots, then round-robin stepping
`timescale 1ns/1ps
`default_nettype none

module env_slot_sequencer #(
    parameter int VOICES = 8,
    parameter int V_ENVS = 8,
    localparam int V_W = (VOICES > 1) ? $clog2(VOICES) : 1,
    localparam int E_W = (V_ENVS > 1) ? $clog2(V_ENVS) : 1
) (
    input  logic           sCLK_XVXENVS,
    input  logic           reset_reg_N,
    output logic [V_W-1:0] slot_voice,
    output logic [E_W-1:0] slot_env,
    output logic           slot_go,
    output logic           init_wr
);

    logic last_env;
    logic last_voice;

    assign last_env   = slot_env == E_W'(V_ENVS - 1);
    assign last_voice = slot_voice == V_W'(VOICES - 1);

    always_ff @(posedge sCLK_XVXENVS or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            slot_voice <= '0;
            slot_env   <= '0;
            slot_go    <= 1'b0;
            init_wr    <= 1'b1;  // sweep starts right out of reset
        end else if (last_env) begin
            slot_env   <= '0;
            slot_voice <= last_voice ? '0 : slot_voice + 1'b1;
            if (last_voice) begin
                init_wr <= 1'b0;
                slot_go <= 1'b1;
            end
        end else begin
            slot_env <= slot_env + 1'b1;  // envelope index fastest
        end
    end

    a_env_range: assert property (
        @(posedge sCLK_XVXENVS) disable iff (!reset_reg_N) int'(slot_env) < V_ENVS
    ) else $error("env_slot_sequencer: slot_env out of range");

endmodule

`default_nettype wire

//--- design/env_param_regs.sv
// envelope parameter registers: bus write/readback and per-slot rate/level fetch
`timescale 1ns/1ps
`default_nettype none

module env_param_regs #(
    parameter int V_ENVS = 8,
    localparam int E_W = (V_ENVS > 1) ? $clog2(V_ENVS) : 1
) (
    input  logic                              sCLK_XVXENVS,
    input  logic                              reset_reg_N,
    input  logic                              write,
    input  logic                              read,
    input  logic [env_cfg_pkg::ADDR_W-1:0]    adr,
    input  logic [env_cfg_pkg::DATA_W-1:0]    wr_data,
    output logic [env_cfg_pkg::DATA_W-1:0]    rd_data,
    input  logic [E_W-1:0]                    slot_env,
    output logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_rate,
    output logic [env_cfg_pkg::NUM_SEG-1:0][env_cfg_pkg::DATA_W-1:0] seg_level
);

    localparam int DW = env_cfg_pkg::DATA_W;
    localparam int NS = env_cfg_pkg::NUM_SEG;

    logic [DW-1:0] rate_r [V_ENVS][NS];
    logic [DW-1:0] level_r [V_ENVS][NS];
    env_cfg_pkg::param_addr_u pa;
    logic [E_W-1:0] bus_env;
    logic env_ok;

    assign pa.addr = adr;
    assign bus_env = pa.f.env_idx[E_W-1:0];
    assign env_ok  = int'(pa.f.env_idx) < V_ENVS;  // upper envelopes unmapped

    always_ff @(posedge sCLK_XVXENVS or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            for (int e = 0; e < V_ENVS; e++) begin
                for (int s = 0; s < NS; s++) begin
                    rate_r[e][s]  <= '0;
                    level_r[e][s] <= '0;
                end
            end
            rd_data <= '0;
        end else begin
            if (write && env_ok) begin
                if (pa.f.is_level)
                    level_r[bus_env][pa.f.seg] <= wr_data;
                else
                    rate_r[bus_env][pa.f.seg] <= wr_data;
            end
            if (read) begin
                if (!env_ok)
                    rd_data <= '0;
                else if (pa.f.is_level)
                    rd_data <= level_r[bus_env][pa.f.seg];
                else
                    rd_data <= rate_r[bus_env][pa.f.seg];
            end
        end
    end

    // lines up with rd_state of the same slot
    always_ff @(posedge sCLK_XVXENVS) begin
        for (int s = 0; s < NS; s++) begin
            seg_rate[s]  <= rate_r[slot_env][s];
            seg_level[s] <= level_r[slot_env][s];
        end
    end

    a_no_rw_clash: assert property (
        @(posedge sCLK_XVXENVS) disable iff (!reset_reg_N) !(write && read)
    ) else $error("env_param_regs: write and read strobes high together");

endmodule

`default_nettype wire

//--- design/env_state_pkg.sv
// envelope state package: phase encoding and fixed-point level format
`default_nettype none

package env_state_pkg;

    typedef enum logic [3:0] {
        IDLE,
        ATTACK,
        HOLD1,
        DECAY1,
        HOLD2,
        DECAY2,
        SUSTAIN,
        RELEASE,
        DONE
    } env_phase_e;

    localparam int LEVEL_W   = 37;
    localparam int FRAC_W    = 29;  // integer level sits above this
    localparam int NUM_SHIFT = 22;

    // phase, level, step, start level
    localparam int STATE_W = 4 + LEVEL_W + LEVEL_W + 8;

endpackage

`default_nettype wire

//--- design/env_cfg_pkg.sv
// envelope configuration package: register address map and segment numbering
`default_nettype none

package env_cfg_pkg;

    localparam int ADDR_W  = 7;
    localparam int DATA_W  = 8;
    localparam int NUM_SEG = 4;

    // segment index into the rate/level registers
    localparam logic [1:0] SEG_ATTACK  = 2'd0;
    localparam logic [1:0] SEG_DECAY1  = 2'd1;
    localparam logic [1:0] SEG_DECAY2  = 2'd2;  // level of this one is the sustain level
    localparam logic [1:0] SEG_RELEASE = 2'd3;

    // bus address, flat or split into envelope/kind/segment
    typedef union packed {
        logic [ADDR_W-1:0] addr;
        struct packed {
            logic [3:0] env_idx;
            logic       is_level;  // set for level, clear for rate
            logic [1:0] seg;
        } f;
    } param_addr_u;

endpackage

`default_nettype wire
